// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module sound_top_tb -f sim.f -o sound_top_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sound_top_sim > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "Checks failed" "$log_file"; then
  echo "simulation reported failure"
  exit 1
fi

if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

echo "simulation finished without failure"
exit 0

// File: sim.f
source/sound_pkg.sv
source/port_decode.sv
source/sound_regs.sv
source/audio_mixer.sv
source/sound_top.sv
tb/tb_clock.sv
tb/sound_top_chk.sv
tb/sound_top_tb.sv

// File: source/audio_mixer.sv
`timescale 1ns/1ps

module audio_mixer #(
  parameter int comp_f = sound_pkg::comp_f_default,
  parameter int comp_a = sound_pkg::comp_a_default
) (
  input  logic                         clk_28mhz,
  input  logic                         rst,
  input  sound_pkg::psg_pair_t         psg_in,
  input  logic [sound_pkg::data_w-1:0] covox,
  input  logic                         beeper,
  output sound_pkg::audio_pair_t       audio_out
);

  localparam int aw    = sound_pkg::audio_w;
  localparam int psg_w = sound_pkg::psg_w;

  // bit weights of the three sources in the sum
  localparam int psg_shift = 4;
  localparam int pcm_shift = 6;

  // knee point and the output level reached there
  localparam int comp_x = ((32767 * (comp_f - 1)) / (comp_f * comp_a - 1)) + 1;
  localparam int comp_b = comp_x * comp_a;

  // covox and beeper are mono, same term on both channels
  logic [aw-1:0] shared_term;

  // stage 1 result, raw sum per channel
  sound_pkg::audio_pair_t pre;

  // generator sample sign-extended and weighted, wraps mod 2^16
  function automatic logic [aw-1:0] mix_sum(
    input logic signed [psg_w-1:0] psg,
    input logic        [aw-1:0]    shared
  );
    logic signed [aw-1:0] psg_ext;
    psg_ext = psg;
    mix_sum = (psg_ext <<< psg_shift) + shared;
  endfunction

  // soft knee on the magnitude, sign put back afterwards
  function automatic logic [aw-1:0] compr(input logic [aw-1:0] inp);
    logic [aw-1:0] neg;
    logic [31:0]   mag;
    logic [31:0]   res;
    logic [aw-1:0] out;
    neg = ~inp + 1'b1;
    mag = inp[aw-1] ? neg : inp;
    if (mag < comp_x) begin
      // linear part below the knee
      res = mag * comp_a;
    end else begin
      res = ((mag - comp_x) / comp_f) + comp_b;
    end
    out   = res[aw-1:0];
    compr = inp[aw-1] ? (~out + 1'b1) : out;
  endfunction

  assign shared_term = (aw'(covox) << pcm_shift) + (aw'(beeper) << pcm_shift);

  // stage 1, summing
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      pre <= '0;
    end else begin
      pre.left  <= mix_sum(psg_in.left, shared_term);
      pre.right <= mix_sum(psg_in.right, shared_term);
    end
  end

  // stage 2, compressor
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      audio_out <= '0;
    end else begin
      audio_out.left  <= compr(pre.left);
      audio_out.right <= compr(pre.right);
    end
  end

endmodule

// File: source/port_decode.sv
`timescale 1ns/1ps

module port_decode (
  input  logic               clk_28mhz,
  input  logic               rst,
  input  sound_pkg::wb_req_t wb_req,
  output logic               wb_ack,
  output sound_pkg::reg_wr_t reg_wr
);

  // low address byte selects the port
  logic [7:0] low_adr;

  // access already answered, stb not yet dropped
  logic served;

  // new access seen this cycle
  logic hit;

  // write hits per port
  logic beeper_sel;
  logic covox_sel;

  assign low_adr = wb_req.adr[7:0];

  assign hit = wb_req.cyc & wb_req.stb & ~wb_ack & ~served;

  assign beeper_sel = (low_adr == sound_pkg::port_beeper);
  assign covox_sel  = (low_adr == sound_pkg::port_covox);

  // single-cycle ack, one cycle after the request shows up
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      wb_ack <= 1'b0;
      served <= 1'b0;
    end else begin
      wb_ack <= hit;
      // hold off a second ack until the master drops stb
      served <= wb_req.cyc & wb_req.stb & (served | wb_ack);
    end
  end

  // strobes leave on the same edge as the ack
  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      reg_wr.beeper_wr <= 1'b0;
      reg_wr.covox_wr  <= 1'b0;
    end else begin
      reg_wr.beeper_wr <= hit & wb_req.we & beeper_sel;
      reg_wr.covox_wr  <= hit & wb_req.we & covox_sel;
    end
    // data byte rides along with the strobes
    if (hit) begin
      reg_wr.data <= wb_req.dat;
    end
  end

endmodule

// File: source/sound_pkg.sv
package sound_pkg;

  // bus and sample widths
  localparam int addr_w  = 16;
  localparam int data_w  = 8;
  localparam int psg_w   = 12;
  localparam int audio_w = 16;

  // port map, compared against the low address byte only
  localparam logic [7:0] port_beeper = 8'hFE;
  localparam logic [7:0] port_covox  = 8'hFB;

  // beeper lives in bit 4 of the FE port, the rest is border colour
  localparam int beeper_bit = 4;

  // soft-knee compressor defaults
  // comp_f is the knee divisor, comp_a the slope below the knee
  localparam int comp_f_default = 4;
  localparam int comp_a_default = 2;

  // wishbone classic request from the bus master
  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [addr_w-1:0] adr;
    logic [data_w-1:0] dat;
  } wb_req_t;

  // decoded register write, at most one strobe high
  typedef struct packed {
    logic              beeper_wr;
    logic              covox_wr;
    logic [data_w-1:0] data;
  } reg_wr_t;

  // sample pair from the external sound generator
  typedef struct packed {
    logic signed [psg_w-1:0] left;
    logic signed [psg_w-1:0] right;
  } psg_pair_t;

  // mixed and compressed output pair
  typedef struct packed {
    logic [audio_w-1:0] left;
    logic [audio_w-1:0] right;
  } audio_pair_t;

endpackage

// File: source/sound_regs.sv
`timescale 1ns/1ps

module sound_regs (
  input  logic                        clk_28mhz,
  input  logic                        rst,
  input  sound_pkg::reg_wr_t          reg_wr,
  input  logic [7:0]                  rd_adr,
  output logic [sound_pkg::data_w-1:0] rd_dat,
  output logic                        beeper,
  output logic [sound_pkg::data_w-1:0] covox
);

  // whole FE byte is kept so it reads back unchanged
  logic [sound_pkg::data_w-1:0] fe_reg;

  // unsigned 8-bit pcm sample
  logic [sound_pkg::data_w-1:0] covox_reg;

  always_ff @(posedge clk_28mhz) begin
    if (rst) begin
      fe_reg    <= '0;
      covox_reg <= '0;
    end else begin
      if (reg_wr.beeper_wr) begin
        fe_reg <= reg_wr.data;
      end
      if (reg_wr.covox_wr) begin
        covox_reg <= reg_wr.data;
      end
    end
  end

  // read-back mux, open bus reads as FF
  always_comb begin
    case (rd_adr)
      sound_pkg::port_beeper: begin
        rd_dat = fe_reg;
      end
      sound_pkg::port_covox: begin
        rd_dat = covox_reg;
      end
      default: begin
        rd_dat = 8'hFF;
      end
    endcase
  end

  // to the mixer
  assign beeper = fe_reg[sound_pkg::beeper_bit];
  assign covox  = covox_reg;

endmodule

// File: source/sound_top.sv
`timescale 1ns/1ps

module sound_top #(
  parameter int comp_f = sound_pkg::comp_f_default,
  parameter int comp_a = sound_pkg::comp_a_default
) (
  input  logic                         clk_28mhz,
  input  logic                         rst,
  input  sound_pkg::wb_req_t           wb_req,
  output logic                         wb_ack,
  output logic [sound_pkg::data_w-1:0] wb_dat_o,
  input  sound_pkg::psg_pair_t         psg_in,
  output sound_pkg::audio_pair_t       audio_out
);

  // decoded writes toward the register file
  sound_pkg::reg_wr_t reg_wr;

  // register outputs into the mixer
  logic                         beeper;
  logic [sound_pkg::data_w-1:0] covox;

  port_decode port_decode_i (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .wb_req    (wb_req),
    .wb_ack    (wb_ack),
    .reg_wr    (reg_wr)
  );

  // reads are served straight from the register file
  sound_regs sound_regs_i (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .reg_wr    (reg_wr),
    .rd_adr    (wb_req.adr[7:0]),
    .rd_dat    (wb_dat_o),
    .beeper    (beeper),
    .covox     (covox)
  );

  audio_mixer #(
    .comp_f (comp_f),
    .comp_a (comp_a)
  ) audio_mixer_i (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .psg_in    (psg_in),
    .covox     (covox),
    .beeper    (beeper),
    .audio_out (audio_out)
  );

endmodule

// File: tb/sound_top_chk.sv
`timescale 1ns/1ps

module sound_top_chk (
  input logic                   clk_28mhz,
  input logic                   rst,
  input sound_pkg::wb_req_t     wb_req,
  input logic                   wb_ack,
  input sound_pkg::audio_pair_t audio_out
);

  // count of failed assertions
  int fail_count = 0;

  // ack is a single-cycle pulse
  ack_one_cycle: assert property (
    @(posedge clk_28mhz) disable iff (rst) wb_ack |=> !wb_ack
  ) else begin
    $error("wb_ack stayed high for more than one cycle");
    fail_count++;
  end

  // no ack without an open request
  ack_needs_req: assert property (
    @(posedge clk_28mhz) disable iff (rst) wb_ack |-> (wb_req.cyc && wb_req.stb)
  ) else begin
    $error("wb_ack seen while cyc or stb was low");
    fail_count++;
  end

  // pipeline cleared by reset
  audio_zero_after_reset: assert property (
    @(posedge clk_28mhz) rst |=> (audio_out == '0)
  ) else begin
    $error("audio_out not zero in the cycle after reset");
    fail_count++;
  end

endmodule

// File: tb/sound_top_tb.sv
`timescale 1ns/1ps

module sound_top_tb;

  localparam int comp_f = sound_pkg::comp_f_default;
  localparam int comp_a = sound_pkg::comp_a_default;

  // knee and the output level reached at the knee
  localparam int knee       = ((32767 * (comp_f - 1)) / (comp_f * comp_a - 1)) + 1;
  localparam int knee_level = knee * comp_a;

  localparam int reset_cycles = 5;
  localparam int row_budget   = 20;

  localparam logic [1:0] op_none  = 2'd0;
  localparam logic [1:0] op_write = 2'd1;
  localparam logic [1:0] op_read  = 2'd2;

  typedef struct packed {
    logic [1:0]         op;
    logic [15:0]        adr;
    logic [7:0]         dat;
    logic signed [11:0] psg_l;
    logic signed [11:0] psg_r;
    logic [7:0]         exp_rd;
  } row_t;

  logic                   clk_28mhz;
  logic                   rst;
  sound_pkg::wb_req_t     wb_req;
  logic                   wb_ack;
  logic [7:0]             wb_dat_o;
  sound_pkg::psg_pair_t   psg_in;
  sound_pkg::audio_pair_t audio_out;

  row_t        rows[$];
  logic        table_ready;
  logic [31:0] lfsr_state;

  // model copies of the two port registers
  logic [7:0] model_fe;
  logic [7:0] model_covox;

  tb_clock #(.period_ns(8)) tb_clock_i (.clk_28mhz(clk_28mhz));

  sound_top #(
    .comp_f (comp_f),
    .comp_a (comp_a)
  ) sound_top_i (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .wb_req    (wb_req),
    .wb_ack    (wb_ack),
    .wb_dat_o  (wb_dat_o),
    .psg_in    (psg_in),
    .audio_out (audio_out)
  );

  bind sound_top sound_top_chk sound_top_chk_i (
    .clk_28mhz (clk_28mhz),
    .rst       (rst),
    .wb_req    (wb_req),
    .wb_ack    (wb_ack),
    .audio_out (audio_out)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "run stopped");
  endtask

  // galois lfsr with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [11:0] rand12();
    logic [11:0] v;
    v = '0;
    for (int i = 0; i < 12; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[10:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // expected channel value from weighted sum, 16-bit wrap and soft knee
  function automatic logic [15:0] model_channel(
    input logic signed [11:0] psg,
    input logic        [7:0]  cov,
    input logic               beep
  );
    int                 sum;
    int                 mag;
    int                 res;
    logic signed [15:0] wrapped;
    sum     = int'(psg) * 16 + int'(cov) * 64 + int'(beep) * 64;
    wrapped = sum[15:0];
    mag     = (wrapped < 0) ? -int'(wrapped) : int'(wrapped);
    if (mag < knee) begin
      res = mag * comp_a;
    end else begin
      res = (mag - knee) / comp_f + knee_level;
    end
    if (wrapped < 0) begin
      res = -res;
    end
    return res[15:0];
  endfunction

  task automatic add_row(input logic [1:0] op, input logic [15:0] adr, input logic [7:0] dat,
                         input logic [11:0] l, input logic [11:0] r, input logic [7:0] exp_rd);
    row_t row;
    row = '{op, adr, dat, l, r, exp_rd};
    rows.push_back(row);
  endtask

  task automatic build_table();
    logic [7:0] cov_list[8];
    cov_list = '{8'h00, 8'h01, 8'h40, 8'h80, 8'hDB, 8'hDC, 8'hF0, 8'hFF};
    add_row(op_none, 16'h0000, 8'h00, 12'h000, 12'h000, 8'h00);
    // beeper on and off
    add_row(op_write, 16'h00FE, 8'h10, 12'h000, 12'h000, 8'h00);
    add_row(op_write, 16'h00FE, 8'h00, 12'h000, 12'h000, 8'h00);
    // covox sweep with DB just below the knee and DC just above
    foreach (cov_list[i]) begin
      add_row(op_write, 16'h00FB, cov_list[i], 12'h000, 12'h000, 8'h00);
    end
    // generator extremes
    add_row(op_write, 16'h00FB, 8'h00, 12'h800, 12'h7FF, 8'h00);
    add_row(op_write, 16'h00FE, 8'h10, 12'h800, 12'h7FF, 8'h00);
    add_row(op_write, 16'h00FB, 8'h80, 12'h7FF, 12'h800, 8'h00);
    add_row(op_none, 16'h0000, 8'h00, 12'hFFF, 12'h001, 8'h00);
    for (int i = 0; i < 8; i++) begin
      add_row(op_write, i[0] ? 16'h00FE : 16'h00FB, 8'(i * 53 + 17), rand12(), rand12(), 8'h00);
    end
    add_row(op_none, 16'h0000, 8'h00, rand12(), rand12(), 8'h00);
    add_row(op_none, 16'h0000, 8'h00, rand12(), rand12(), 8'h00);
    // unmatched ports and read-back
    add_row(op_write, 16'h00FE, 8'h5A, 12'h064, 12'hF9C, 8'h00);
    add_row(op_write, 16'h00FB, 8'hC3, 12'h064, 12'hF9C, 8'h00);
    add_row(op_write, 16'h0012, 8'hAA, 12'h064, 12'hF9C, 8'h00);
    add_row(op_write, 16'h7FFD, 8'h55, 12'h064, 12'hF9C, 8'h00);
    add_row(op_read, 16'h00FE, 8'h00, 12'h064, 12'hF9C, 8'h5A);
    add_row(op_read, 16'h00FB, 8'h00, 12'h064, 12'hF9C, 8'hC3);
    add_row(op_read, 16'h0034, 8'h00, 12'h064, 12'hF9C, 8'hFF);
    add_row(op_read, 16'hFF00, 8'h00, 12'h064, 12'hF9C, 8'hFF);
    add_row(op_write, 16'h01FE, 8'h07, 12'h064, 12'hF9C, 8'h00);
    add_row(op_read, 16'h00FE, 8'h00, 12'h064, 12'hF9C, 8'h07);
  endtask

  task automatic bus_access(input row_t row, output logic [7:0] rd);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = (row.op == op_write);
    wb_req.adr = row.adr;
    wb_req.dat = row.dat;
    @(negedge clk_28mhz);
    while (wb_ack !== 1'b1) begin
      @(negedge clk_28mhz);
    end
    rd = wb_dat_o;
    // request held through the ack edge and dropped one cycle later
    @(negedge clk_28mhz);
    assert (wb_ack == 1'b0) else begin
      abort_run("wb_ack stayed high for more than one cycle");
    end
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
    wb_req.we  = 1'b0;
  endtask

  task automatic check_audio(input int idx, input row_t row);
    logic [15:0] exp_l;
    logic [15:0] exp_r;
    exp_l = model_channel(row.psg_l, model_covox, model_fe[sound_pkg::beeper_bit]);
    exp_r = model_channel(row.psg_r, model_covox, model_fe[sound_pkg::beeper_bit]);
    assert (audio_out.left == exp_l) else begin
      abort_run($sformatf("ERROR audio_out.left got %h expected %h at row %0d",
                          audio_out.left, exp_l, idx));
    end
    assert (audio_out.right == exp_r) else begin
      abort_run($sformatf("ERROR audio_out.right got %h expected %h at row %0d",
                          audio_out.right, exp_r, idx));
    end
  endtask

  initial begin
    row_t       row;
    logic [7:0] rd;
    rst         = 1'b1;
    wb_req      = '0;
    psg_in      = '0;
    model_fe    = '0;
    model_covox = '0;
    lfsr_state  = 32'ha9b2_71b1;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (reset_cycles) @(negedge clk_28mhz);
    rst = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      row          = rows[i];
      psg_in.left  = row.psg_l;
      psg_in.right = row.psg_r;
      if (row.op != op_none) begin
        bus_access(row, rd);
      end
      if (row.op == op_read) begin
        assert (rd == row.exp_rd) else begin
          abort_run($sformatf("ERROR wb_dat_o got %h expected %h at row %0d",
                              rd, row.exp_rd, i));
        end
      end
      if (row.op == op_write && row.adr[7:0] == sound_pkg::port_beeper) begin
        model_fe = row.dat;
      end
      if (row.op == op_write && row.adr[7:0] == sound_pkg::port_covox) begin
        model_covox = row.dat;
      end
      // register edge plus two mixer stages
      repeat (3) @(negedge clk_28mhz);
      check_audio(i, row);
    end
    // protocol assertions in the bound checker
    assert (sound_top_i.sound_top_chk_i.fail_count == 0) else begin
      abort_run("a bound assertion on the bus handshake or reset state failed");
    end
    $display("All checks passed");
    $finish;
  end

  // watchdog sized from the table length
  initial begin
    wait (table_ready === 1'b1);
    repeat (rows.size() * row_budget + reset_cycles) @(posedge clk_28mhz);
    abort_run("the run timed out before all table rows were applied");
  end

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int period_ns = 8
) (
  output logic clk_28mhz
);

  initial begin
    clk_28mhz = 1'b0;
    forever #(period_ns / 2) clk_28mhz = ~clk_28mhz;
  end

endmodule
